// File: Makefile
# Verilator simulation of the forget gate testbench

TOP := forget_gate_tb

sim:
	verilator --binary --timing -f sources.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: common/mac_if.sv
/*
 * Link between the row controller and the dot-product accumulator
 * Strobes, operand words and the saturated row sum
 */

`timescale 1ns/1ps
`default_nettype none

interface mac_if;
  import ntm_pkg::*;

  logic                     clear;       // Zero the accumulator
  logic                     pair_valid;  // Add weight * vector
  logic                     bias_valid;  // Add vector as bias
  logic signed [data_w-1:0] weight;
  logic signed [data_w-1:0] vector;
  logic signed [data_w-1:0] sum;         // Saturated Q8.8 result

  // Controller side
  modport ctrl (
    output clear, pair_valid, bias_valid, weight, vector,
    input  sum
  );

  // Accumulator side
  modport acc (
    input  clear, pair_valid, bias_valid, weight, vector,
    output sum
  );

endinterface

`default_nettype wire

// File: common/ntm_pkg.sv
/*
 * Shared definitions for the forget gate datapath
 * Q8.8 word widths, accumulator width, operand select codes
 * and the fixed-point union used by the logistic stage
 */

`default_nettype none

package ntm_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int data_w = 16;  // Q8.8 word
  localparam int frac_w = 8;   // Fraction bits of a word
  localparam int acc_w  = 40;  // Accumulator, Q24.16

  //////////////////////////////////////////////////////////////////////
  // Operand select codes
  //////////////////////////////////////////////////////////////////////

  // Order of the codes is the order of the phases in a row
  localparam logic [1:0] sel_wx   = 2'd0;  // W times x
  localparam logic [1:0] sel_kr   = 2'd1;  // K times r
  localparam logic [1:0] sel_uh   = 2'd2;  // U times h
  localparam logic [1:0] sel_bias = 2'd3;  // Bias on vector_in

  //////////////////////////////////////////////////////////////////////
  // Fixed-point word
  //////////////////////////////////////////////////////////////////////

  // Same 16 bits, read as a signed number or as integer/fraction bytes
  typedef union packed {
    logic signed [data_w-1:0] value;
    struct packed {
      logic [data_w-frac_w-1:0] int_part;  // Upper byte
      logic [frac_w-1:0]        frac_part; // Lower byte
    } fields;
  } fixed_word_u;

endpackage

`default_nettype wire

// File: forget_gate/dot_product_accumulator.sv
/*
 * Multiply-accumulate for one gate row
 * Q8.8 products summed in Q24.16, bias aligned in, result saturated
 */

`timescale 1ns/1ps
`default_nettype none

module dot_product_accumulator (
  input wire logic CLK,
  input wire logic RST,
  mac_if.acc       mac
);
  import ntm_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Accumulate
  //////////////////////////////////////////////////////////////////////

  logic signed [2*data_w-1:0] product;  // Q16.16
  logic signed [acc_w-1:0]    bias_ext; // Q24.16
  logic signed [acc_w-1:0]    acc;
  logic signed [acc_w-1:0]    shifted;  // Back to 8 fraction bits
  logic                       in_range;

  assign product  = mac.weight * mac.vector;
  assign bias_ext = acc_w'(mac.vector) <<< frac_w;  // Sign extend, then align

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc <= '0;
    end else if (mac.clear) begin
      acc <= '0;  // Start of a row
    end else if (mac.pair_valid) begin
      acc <= acc + acc_w'(product);
    end else if (mac.bias_valid) begin
      acc <= acc + bias_ext;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Saturate to Q8.8
  //////////////////////////////////////////////////////////////////////

  assign shifted = acc >>> frac_w;

  // Fits when all bits above the word agree with its sign bit
  assign in_range = (shifted[acc_w-1:data_w-1] == '0) ||
                    (shifted[acc_w-1:data_w-1] == '1);

  always_comb begin
    if (in_range) begin
      mac.sum = shifted[data_w-1:0];
    end else if (shifted[acc_w-1]) begin
      mac.sum = {1'b1, {(data_w-1){1'b0}}};  // 0x8000
    end else begin
      mac.sum = {1'b0, {(data_w-1){1'b1}}};  // 0x7FFF
    end
  end

endmodule

`default_nettype wire

// File: forget_gate/forget_gate_vector.sv
/*
 * Row controller for the forget gate
 * Requests operands phase by phase, drives the accumulator strobes,
 * hands each row sum to the logistic stage and signals the end of a run
 */

`timescale 1ns/1ps
`default_nettype none

module forget_gate_vector #(
  parameter int vec_len  = 4,  // L, also length of h
  parameter int in_len   = 3,  // X
  parameter int word_len = 2   // W
) (
  input  wire logic                       CLK,
  input  wire logic                       RST,

  input  wire logic                       start,
  output      logic                       operand_req,
  output      logic [1:0]                 operand_sel,
  input  wire logic [ntm_pkg::data_w-1:0] weight_in,
  input  wire logic [ntm_pkg::data_w-1:0] vector_in,
  input  wire logic                       operand_valid,

  mac_if.ctrl                             mac,

  output      logic                       sum_enable,     // Row sum to logistic
  input  wire logic                       result_enable,  // Logistic result back
  output      logic                       ready
);
  import ntm_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // States and counters
  //////////////////////////////////////////////////////////////////////

  localparam logic [2:0] st_idle          = 3'd0;
  localparam logic [2:0] st_clear         = 3'd1;  // Clear strobe, first request
  localparam logic [2:0] st_request       = 3'd2;
  localparam logic [2:0] st_wait_sum      = 3'd3;
  localparam logic [2:0] st_wait_logistic = 3'd4;
  localparam logic [2:0] st_done          = 3'd5;

  // Counter wide enough for the longest phase and for the row index
  localparam int max_len = (vec_len > in_len) ?
                           ((vec_len > word_len) ? vec_len : word_len) :
                           ((in_len > word_len) ? in_len : word_len);
  localparam int cnt_w   = $clog2(max_len + 1);

  logic [2:0]       state;
  logic [cnt_w-1:0] row_cnt;   // Gate element l
  logic [cnt_w-1:0] elem_cnt;  // Index inside the phase
  logic             elem_last;
  logic             row_last;
  logic             accept;

  assign accept = operand_req && operand_valid;  // Edge that takes an operand

  // Last element of the current product phase
  always_comb begin
    case (operand_sel)
      sel_wx:  elem_last = (elem_cnt == cnt_w'(in_len - 1));
      sel_kr:  elem_last = (elem_cnt == cnt_w'(word_len - 1));
      default: elem_last = (elem_cnt == cnt_w'(vec_len - 1));  // U times h
    endcase
  end

  assign row_last = (row_cnt == cnt_w'(vec_len - 1));

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state          <= st_idle;
      row_cnt        <= '0;
      elem_cnt       <= '0;
      operand_req    <= 1'b0;
      operand_sel    <= sel_wx;
      mac.clear      <= 1'b0;
      mac.pair_valid <= 1'b0;
      mac.bias_valid <= 1'b0;
      sum_enable     <= 1'b0;
      ready          <= 1'b0;
    end else begin
      // Strobes last one cycle
      mac.clear      <= 1'b0;
      mac.pair_valid <= 1'b0;
      mac.bias_valid <= 1'b0;
      sum_enable     <= 1'b0;
      ready          <= 1'b0;

      case (state)
        st_idle: begin
          if (start) begin  // Only honoured here
            row_cnt     <= '0;
            elem_cnt    <= '0;
            operand_sel <= sel_wx;
            operand_req <= 1'b1;
            mac.clear   <= 1'b1;
            state       <= st_clear;
          end
        end

        // Clear cycle also serves the first request of the row
        st_clear, st_request: begin
          state <= st_request;
          if (accept) begin
            operand_req <= 1'b0;  // Gap of one cycle
            if (operand_sel == sel_bias) begin
              mac.bias_valid <= 1'b1;
              state          <= st_wait_sum;
            end else begin
              mac.pair_valid <= 1'b1;
              if (elem_last) begin
                elem_cnt    <= '0;
                operand_sel <= operand_sel + 2'd1;  // Codes follow phase order
              end else begin
                elem_cnt <= elem_cnt + 1'b1;
              end
            end
          end else if (!operand_req) begin
            operand_req <= 1'b1;  // Next request after the gap
          end
        end

        st_wait_sum: begin  // Bias lands in the accumulator now
          sum_enable <= 1'b1;
          state      <= st_wait_logistic;
        end

        st_wait_logistic: begin
          if (result_enable) begin
            if (row_last) begin
              ready <= 1'b1;
              state <= st_done;
            end else begin
              row_cnt     <= row_cnt + 1'b1;
              operand_sel <= sel_wx;
              operand_req <= 1'b1;
              mac.clear   <= 1'b1;
              state       <= st_clear;
            end
          end
        end

        st_done: state <= st_idle;  // ready is high here

        default: state <= st_idle;
      endcase
    end
  end

  // Operand words, taken on the accepting edge
  always_ff @(posedge CLK) begin
    if (accept) begin
      mac.weight <= weight_in;  // Don't care in bias phase
      mac.vector <= vector_in;
    end
  end

endmodule

`default_nettype wire

// File: hdl/forget_gate_top.sv
/*
 * Forget gate top level
 * Controller, accumulator and sigmoid joined behind plain host ports
 */

`timescale 1ns/1ps
`default_nettype none

module forget_gate_top #(
  parameter int vec_len  = 4,
  parameter int in_len   = 3,
  parameter int word_len = 2
) (
  input  wire logic                       CLK,
  input  wire logic                       RST,

  input  wire logic                       start,
  output      logic                       operand_req,
  output      logic [1:0]                 operand_sel,
  input  wire logic [ntm_pkg::data_w-1:0] weight_in,
  input  wire logic [ntm_pkg::data_w-1:0] vector_in,
  input  wire logic                       operand_valid,

  output      logic [ntm_pkg::data_w-1:0] f_out,
  output      logic                       f_out_enable,
  output      logic                       ready
);
  import ntm_pkg::*;

  mac_if       mac ();
  logic        sum_enable;
  fixed_word_u logistic_in;  // Row sum as seen by the sigmoid

  assign logistic_in.value = mac.sum;

  // Sequencing of rows and operand phases
  forget_gate_vector #(
    .vec_len  (vec_len),
    .in_len   (in_len),
    .word_len (word_len)
  ) u_ctrl (
    .CLK           (CLK),
    .RST           (RST),
    .start         (start),
    .operand_req   (operand_req),
    .operand_sel   (operand_sel),
    .weight_in     (weight_in),
    .vector_in     (vector_in),
    .operand_valid (operand_valid),
    .mac           (mac.ctrl),
    .sum_enable    (sum_enable),
    .result_enable (f_out_enable),  // Result doubles as row done
    .ready         (ready)
  );

  dot_product_accumulator u_acc (
    .CLK (CLK),
    .RST (RST),
    .mac (mac.acc)
  );

  logistic_pwl u_logistic (
    .CLK        (CLK),
    .RST        (RST),
    .in_word    (logistic_in),
    .in_enable  (sum_enable),
    .out_word   (f_out),
    .out_enable (f_out_enable)
  );

endmodule

`default_nettype wire

// File: hdl/logistic_pwl.sv
/*
 * Registered piecewise-linear sigmoid on a Q8.8 word
 */

`timescale 1ns/1ps
`default_nettype none

module logistic_pwl (
  input  wire logic                       CLK,
  input  wire logic                       RST,
  input  wire ntm_pkg::fixed_word_u       in_word,
  input  wire logic                       in_enable,
  output      logic [ntm_pkg::data_w-1:0] out_word,
  output      logic                       out_enable
);
  import ntm_pkg::*;

  // Segment constants in Q8.8
  localparam logic [data_w-1:0] one_q    = data_w'(256);  // 1.0
  localparam logic [data_w-1:0] off_far  = data_w'(216);  // 0.84375
  localparam logic [data_w-1:0] off_mid  = data_w'(160);  // 0.625
  localparam logic [data_w-1:0] off_near = data_w'(128);  // 0.5

  fixed_word_u       abs_word;  // |x|, read through the byte fields
  logic [data_w-1:0] mag;
  logic              neg;
  logic [data_w-1:0] y_pos;     // Sigmoid of |x|
  logic [data_w-1:0] y;

  assign neg            = in_word.value[data_w-1];
  assign abs_word.value = neg ? -in_word.value : in_word.value;
  assign mag            = abs_word.value;  // 0x8000 reads as 128.0

  //////////////////////////////////////////////////////////////////////
  // Segment select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (abs_word.fields.int_part >= 8'd5) begin
      y_pos = one_q;
    end else if (abs_word.fields.int_part > 8'd2 ||
                 (abs_word.fields.int_part == 8'd2 &&
                  abs_word.fields.frac_part >= 8'h60)) begin  // From 2.375
      y_pos = (mag >> 5) + off_far;
    end else if (abs_word.fields.int_part >= 8'd1) begin
      y_pos = (mag >> 3) + off_mid;
    end else begin
      y_pos = (mag >> 2) + off_near;
    end
  end

  assign y = neg ? (one_q - y_pos) : y_pos;  // Odd symmetry around 0.5

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_enable <= 1'b0;
    end else begin
      out_enable <= in_enable;
    end
  end

  always_ff @(posedge CLK) begin
    if (in_enable) begin
      out_word <= y;
    end
  end

endmodule

`default_nettype wire

// File: sources.f
common/ntm_pkg.sv
common/mac_if.sv
forget_gate/dot_product_accumulator.sv
forget_gate/forget_gate_vector.sv
hdl/logistic_pwl.sv
hdl/forget_gate_top.sv
verification/forget_gate_tb.sv

// File: verification/forget_gate_tb.sv
/*
 * Directed testbench for the forget gate top level
 * Host responder with LFSR delays, reference model, output monitor, watchdog
 */

`timescale 1ns/1ps
`default_nettype none

module forget_gate_tb;
  import ntm_pkg::*;

  localparam int vec_len  = 4;
  localparam int in_len   = 3;
  localparam int word_len = 2;
  localparam int n_req    = in_len + word_len + vec_len + 1;  // Requests per row
  localparam int n_runs   = 7;                               // Runs over all tests
  localparam int limit_ns = (n_runs * vec_len * n_req * 8 + 500) * 10;

  logic        CLK;
  logic        RST;
  logic        start;
  logic        operand_req;
  logic [1:0]  operand_sel;
  logic [15:0] weight_in;
  logic [15:0] vector_in;
  logic        operand_valid;
  logic [15:0] f_out;
  logic        f_out_enable;
  logic        ready;

  // Operands of one run in Q8.8
  logic [15:0] w_mat [vec_len][in_len];
  logic [15:0] x_vec [in_len];
  logic [15:0] k_mat [vec_len][word_len];
  logic [15:0] r_vec [word_len];
  logic [15:0] u_mat [vec_len][vec_len];
  logic [15:0] h_vec [vec_len];
  logic [15:0] b_vec [vec_len];
  logic [15:0] exp_f [vec_len];  // Model result per row

  logic [31:0] lfsr;
  int          value_errs;
  int          order_errs;
  int          other_errs;
  int          f_cnt;        // f_out_enable pulses in this run
  int          ready_cnt;
  logic        rand_delay;   // Host answers after 0 to 3 cycles
  logic        stray_start;  // Extra start inside row 1

  forget_gate_top #(
    .vec_len  (vec_len),
    .in_len   (in_len),
    .word_len (word_len)
  ) uut (
    .CLK           (CLK),
    .RST           (RST),
    .start         (start),
    .operand_req   (operand_req),
    .operand_sel   (operand_sel),
    .weight_in     (weight_in),
    .vector_in     (vector_in),
    .operand_valid (operand_valid),
    .f_out         (f_out),
    .f_out_enable  (f_out_enable),
    .ready         (ready)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  initial begin
    #(limit_ns);
    $display("Watchdog expired, the DUT stopped making progress");
    $display("SIMULATION FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Random numbers and reference model
  //////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [15:0] draw_bits(int n);
    logic [15:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[14:0], fb};
    end
    return v;
  endfunction

  function automatic logic [15:0] signed_draw(int n);
    logic [15:0] v;
    v = draw_bits(n);
    if (v[n-1])
      v = v | (16'hFFFF << n);  // Sign extend
    return v;
  endfunction

  // Q16.16 products plus aligned bias, then Q8.8 saturation and sigmoid
  function automatic logic [15:0] gate_model(int l);
    longint acc;
    longint s;
    longint a;
    longint y;
    acc = longint'($signed(b_vec[l])) * 256;
    for (int i = 0; i < in_len; i++)
      acc += longint'($signed(w_mat[l][i])) * longint'($signed(x_vec[i]));
    for (int k = 0; k < word_len; k++)
      acc += longint'($signed(k_mat[l][k])) * longint'($signed(r_vec[k]));
    for (int p = 0; p < vec_len; p++)
      acc += longint'($signed(u_mat[l][p])) * longint'($signed(h_vec[p]));
    s = acc >>> 8;
    if (s > 32767)
      s = 32767;
    else if (s < -32768)
      s = -32768;
    a = (s < 0) ? -s : s;
    if (a >= 1280)       // From 5.0
      y = 256;
    else if (a >= 608)   // From 2.375
      y = a / 32 + 216;
    else if (a >= 256)
      y = a / 8 + 160;
    else
      y = a / 4 + 128;
    if (s < 0)
      y = 256 - y;
    return 16'(y);
  endfunction

  // All operands zero or small random words when rnd is set
  task automatic fill_operands(bit rnd);
    for (int l = 0; l < vec_len; l++) begin
      for (int i = 0; i < in_len; i++)
        w_mat[l][i] = rnd ? signed_draw(8) : 16'h0;
      for (int k = 0; k < word_len; k++)
        k_mat[l][k] = rnd ? signed_draw(8) : 16'h0;
      for (int p = 0; p < vec_len; p++)
        u_mat[l][p] = rnd ? signed_draw(8) : 16'h0;
      b_vec[l] = rnd ? signed_draw(10) : 16'h0;  // Up to 2.0
      h_vec[l] = rnd ? signed_draw(8) : 16'h0;
    end
    for (int i = 0; i < in_len; i++)
      x_vec[i] = rnd ? signed_draw(8) : 16'h0;
    for (int k = 0; k < word_len; k++)
      r_vec[k] = rnd ? signed_draw(8) : 16'h0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Host side and monitor
  //////////////////////////////////////////////////////////////////////

  // Sampled at the falling edge away from the driving edge
  always @(negedge CLK) begin
    if (f_out_enable) begin
      if (f_cnt < vec_len && f_out !== exp_f[f_cnt]) begin
        $display("ERR f_out row %0d: got %h, expected %h", f_cnt, f_out, exp_f[f_cnt]);
        value_errs++;
      end
      f_cnt++;
    end
    if (ready)
      ready_cnt++;
  end

  // Starts a run and answers all requests until ready
  task automatic serve_one_run();
    int          cnt [4];   // Element index per select
    int          guard;
    logic [1:0]  exp_sel;
    logic [15:0] wv;
    logic [15:0] vv;
    for (int l = 0; l < vec_len; l++)
      exp_f[l] = gate_model(l);
    f_cnt     = 0;
    ready_cnt = 0;
    start <= 1'b1;
    @(posedge CLK);
    start <= 1'b0;
    for (int l = 0; l < vec_len; l++) begin
      cnt = '{0, 0, 0, 0};
      for (int n = 0; n < n_req; n++) begin
        guard = 0;
        do begin
          @(posedge CLK);
          guard++;
        end while (!operand_req && guard < 100);
        if (!operand_req) begin
          $display("No operand request for row %0d, request %0d", l, n);
          other_errs++;
          return;
        end
        if (n < in_len)
          exp_sel = sel_wx;
        else if (n < in_len + word_len)
          exp_sel = sel_kr;
        else if (n < n_req - 1)
          exp_sel = sel_uh;
        else
          exp_sel = sel_bias;
        if (operand_sel !== exp_sel) begin
          $display("ERR operand_sel row %0d req %0d: got %h, expected %h",
                   l, n, operand_sel, exp_sel);
          order_errs++;
        end
        case (operand_sel)
          sel_wx: begin
            wv = w_mat[l][cnt[0]];
            vv = x_vec[cnt[0]];
          end
          sel_kr: begin
            wv = k_mat[l][cnt[1]];
            vv = r_vec[cnt[1]];
          end
          sel_uh: begin
            wv = u_mat[l][cnt[2]];
            vv = h_vec[cnt[2]];
          end
          default: begin
            wv = 16'h7FFF;  // Must be ignored
            vv = b_vec[l];
          end
        endcase
        cnt[operand_sel]++;
        if (rand_delay)
          repeat (draw_bits(2)) @(posedge CLK);
        operand_valid <= 1'b1;
        weight_in     <= wv;
        vector_in     <= vv;
        if (stray_start && l == 1 && n == in_len)
          start <= 1'b1;  // DUT is busy so no effect expected
        @(posedge CLK);
        operand_valid <= 1'b0;
        start         <= 1'b0;
      end
    end
    guard = 0;
    do begin
      @(posedge CLK);
      guard++;
    end while (!ready && guard < 20);
    if (!ready) begin
      $display("ready did not pulse after the last row");
      other_errs++;
    end
    if (f_cnt != vec_len || ready_cnt != 1) begin
      $display("Run gave %0d results and %0d ready pulses", f_cnt, ready_cnt);
      other_errs++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic check_reset_state();
    if (operand_req !== 1'b0 || f_out_enable !== 1'b0 || ready !== 1'b0) begin
      $display("ERR after reset: operand_req %h f_out_enable %h ready %h, expected 0",
               operand_req, f_out_enable, ready);
      other_errs++;
    end
  endtask

  task automatic drive_zero_operands();
    fill_operands(1'b0);
    serve_one_run();  // Each f is 0.5
  endtask

  task automatic verify_request_order();
    fill_operands(1'b1);
    serve_one_run();
  endtask

  // Boundaries of both signs where the last row saturates the sum
  task automatic sweep_sigmoid_segments();
    fill_operands(1'b0);
    b_vec       = '{16'h0080, 16'h0100, 16'h0260, 16'h0000};
    w_mat[3][0] = 16'h7FFF;
    x_vec[0]    = 16'h7FFF;
    serve_one_run();
    fill_operands(1'b0);
    b_vec       = '{16'hFF40, 16'hFE80, 16'hFD00, 16'h0500};
    w_mat[3][0] = 16'h7FFF;
    x_vec[0]    = 16'h8000;  // Large negative product
    serve_one_run();
  endtask

  task automatic random_back_to_back();
    logic idle_req;
    rand_delay  = 1'b1;
    stray_start = 1'b1;
    repeat (3) begin
      fill_operands(1'b1);
      serve_one_run();
    end
    idle_req = 1'b0;
    repeat (20) begin
      @(posedge CLK);
      idle_req = idle_req | operand_req;
    end
    if (idle_req || f_cnt != vec_len) begin
      $display("Activity after the last run, stray start was not ignored");
      other_errs++;
    end
  endtask

  initial begin
    RST           = 1'b1;
    start         = 1'b0;
    operand_valid = 1'b0;
    weight_in     = 16'h0;
    vector_in     = 16'h0;
    lfsr          = 32'h6ee7;
    value_errs    = 0;
    order_errs    = 0;
    other_errs    = 0;
    f_cnt         = 0;
    ready_cnt     = 0;
    rand_delay    = 1'b0;
    stray_start   = 1'b0;
    repeat (4) @(posedge CLK);
    RST <= 1'b0;
    @(posedge CLK);
    check_reset_state();
    drive_zero_operands();
    verify_request_order();
    sweep_sigmoid_segments();
    random_back_to_back();
    $display("Errors: value %0d, order %0d, other %0d", value_errs, order_errs, other_errs);
    if (value_errs + order_errs + other_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
